// ==== common/mcu_defs.svh ====
/*
 * Widths and constants shared by the MCU peripheral block.
 * Included by the packages and the top level before use.
 */
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// Data bus
`define MCU_WORD_W 32 // Data word width
`define MCU_ADDR_W 32 // Byte address width

// Peripheral window, top 64 KiB
`define MCU_PERIPH_BASE 16'hFFFF // Upper address half of the window
`define MCU_OFFSET_W 8 // Register offset field in the low byte

// Dataslot interface
`define MCU_SLOT_ID_W 16 // Dataslot id
`define MCU_DS_ERR_W 3 // Result code, zero is OK

`endif

// ==== common/mcu_bus_pkg.sv ====
/*
 * Data-bus word and address types, plus the low-byte register map
 * of the peripheral window. Referenced by scoped names only.
 */
`default_nettype none

`include "mcu_defs.svh"

package mcu_bus_pkg;

	typedef logic [`MCU_WORD_W-1:0] word_t; // One bus word
	typedef logic [`MCU_ADDR_W-1:0] addr_t; // Byte address

	// Register offsets within the window
	typedef enum logic [`MCU_OFFSET_W-1:0] {
		KEY0       = 8'h20, // Controller key words
		KEY1       = 8'h24,
		KEY2       = 8'h28,
		KEY3       = 8'h2C,
		JOY0       = 8'h30, // Joystick words
		JOY1       = 8'h34,
		JOY2       = 8'h38,
		JOY3       = 8'h3C,
		DS_ID      = 8'h80, // Target dataslot parameters
		DS_BRIDGE  = 8'h84,
		DS_LEN     = 8'h88,
		DS_OFFSET  = 8'h8C,
		DS_CTRL    = 8'h90, // Command on write, status on read
		SYS_FREQ   = 8'h98, // Cycles per millisecond minus one
		UPD_FLAG   = 8'hB0, // Read clears
		UPD_ID     = 8'hB4,
		UPD_SIZE   = 8'hB8,
		TMR1_COUNT = 8'hC4, // Bit 0 on write clears
		TMR1_CMP   = 8'hC8, // Write also enables the irq
		TMR2_COUNT = 8'hCC,
		TMR_STATE  = 8'hF4  // {irq, enable}
	} reg_offset_e;

endpackage

`default_nettype wire

// ==== common/mcu_dataslot_pkg.sv ====
/*
 * Dataslot id, result code and DS_CTRL command bit positions.
 */
`default_nettype none

`include "mcu_defs.svh"

package mcu_dataslot_pkg;

	typedef logic [`MCU_SLOT_ID_W-1:0] slot_id_t; // Asset id
	typedef logic [`MCU_DS_ERR_W-1:0] ds_err_t; // Zero means OK

	// Bit positions in a DS_CTRL write
	typedef enum logic [1:0] {
		DS_CMD_READ   = 2'd0, // Read pulse
		DS_CMD_WRITE  = 2'd1, // Write pulse
		DS_CMD_IRQ_EN = 2'd2  // Done-edge interrupt enable
	} ds_cmd_e;

endpackage

`default_nettype wire

// ==== logic/ms_timer.sv ====
/*
 * Millisecond timer. A cycle counter wraps at sys_freq and advances
 * count; irq latches when count hits a nonzero compare at a tick.
 */
`default_nettype none

module ms_timer (
	input  logic                clk_sys,
	input  logic                reset_n,
	input  logic                clear,    // Sync clear, also drops irq
	input  mcu_bus_pkg::word_t  sys_freq, // Cycles per tick minus one
	input  mcu_bus_pkg::word_t  compare,  // Zero disables the match
	output mcu_bus_pkg::word_t  count,
	output logic                irq
);

	mcu_bus_pkg::word_t tick_cnt; // Cycles since last tick
	logic               tick;

	assign tick = (tick_cnt >= sys_freq); // Also catches a lowered sys_freq

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt <= '0;
			count    <= '0;
			irq      <= 1'b0;
		end else if (clear) begin
			tick_cnt <= '0;
			count    <= '0;
			irq      <= 1'b0;
		end else if (tick) begin
			tick_cnt <= '0;
			count    <= count + 1'b1;
			// Match on the value before the increment
			if (compare != '0 && count == compare) begin
				irq <= 1'b1; // Sticky until next clear
			end
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== dataslot/target_dataslot_ctrl.sv ====
/*
 * Target-dataslot command registers. Holds the four parameters, fires
 * read/write pulses from a DS_CTRL write and raises ext_irq on done.
 */
`default_nettype none

module target_dataslot_ctrl (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        wr_id,     // Write strobes from decode
	input  logic                        wr_bridge,
	input  logic                        wr_len,
	input  logic                        wr_offset,
	input  logic                        wr_ctrl,
	input  mcu_bus_pkg::word_t          wdata,
	input  logic                        target_dataslot_ack,  // Host levels
	input  logic                        target_dataslot_done,
	input  mcu_dataslot_pkg::ds_err_t   target_dataslot_err,
	output logic                        target_dataslot_read,
	output logic                        target_dataslot_write,
	output mcu_dataslot_pkg::slot_id_t  target_dataslot_id,
	output mcu_bus_pkg::word_t          target_dataslot_bridgeaddr,
	output mcu_bus_pkg::word_t          target_dataslot_length,
	output mcu_bus_pkg::word_t          target_dataslot_slotoffset,
	output mcu_bus_pkg::word_t          status,
	output logic                        ext_irq
);

	logic irq_en;  // Done-edge interrupt enable
	logic done_q;  // Done, registered
	logic done_q2; // Previous done, for the edge

	// Command parameters
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
		end else begin
			if (wr_id)
				target_dataslot_id <= wdata[$bits(mcu_dataslot_pkg::slot_id_t)-1:0];
			if (wr_bridge)
				target_dataslot_bridgeaddr <= wdata;
			if (wr_len)
				target_dataslot_length <= wdata;
			if (wr_offset)
				target_dataslot_slotoffset <= wdata;
		end
	end

	// Command pulses and interrupt
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
			irq_en                <= 1'b0;
			done_q                <= 1'b0;
			done_q2               <= 1'b0;
			ext_irq               <= 1'b0;
		end else begin
			// One cycle each, only on a DS_CTRL write
			target_dataslot_read  <= wr_ctrl & wdata[mcu_dataslot_pkg::DS_CMD_READ];
			target_dataslot_write <= wr_ctrl & wdata[mcu_dataslot_pkg::DS_CMD_WRITE];
			if (wr_ctrl)
				irq_en <= wdata[mcu_dataslot_pkg::DS_CMD_IRQ_EN];
			done_q  <= target_dataslot_done;
			done_q2 <= done_q;
			ext_irq <= irq_en & done_q & ~done_q2; // Rising edge of done
		end
	end

	// Status word {ack, done, err}, zero extended
	assign status = mcu_bus_pkg::word_t'({target_dataslot_ack, target_dataslot_done,
		target_dataslot_err});

endmodule

`default_nettype wire

// ==== dataslot/dataslot_update_capture.sv ====
/*
 * Dataslot-update capture. A pulse sets the flag and latches id and
 * size; reading UPD_FLAG clears the flag unless a new pulse arrives.
 */
`default_nettype none

module dataslot_update_capture (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        dataslot_update, // One-cycle pulse
	input  mcu_dataslot_pkg::slot_id_t  dataslot_update_id,
	input  mcu_bus_pkg::word_t          dataslot_update_size,
	input  logic                        rd_flag,         // UPD_FLAG read strobe
	output logic                        flag,
	output mcu_dataslot_pkg::slot_id_t  upd_id,
	output mcu_bus_pkg::word_t          upd_size
);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			flag     <= 1'b0;
			upd_id   <= '0;
			upd_size <= '0;
		end else if (dataslot_update) begin
			// New update wins over a clearing read
			flag     <= 1'b1;
			upd_id   <= dataslot_update_id;
			upd_size <= dataslot_update_size;
		end else if (rd_flag) begin
			flag <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mcu_periph_bus.sv ====
/*
 * Peripheral register block on the CPU data bus. Decodes the top 64 KiB
 * window, hosts the timer registers and answers every command one cycle
 * later with a registered read word.
 */
`default_nettype none

`include "mcu_defs.svh"

module mcu_periph_bus (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        dbus_valid, // One-cycle command strobe
	input  logic                        dbus_wr,
	input  mcu_bus_pkg::addr_t          dbus_addr,
	input  mcu_bus_pkg::word_t          dbus_wdata,
	output logic                        dbus_rsp_ready,
	output mcu_bus_pkg::word_t          dbus_rsp_data,
	input  mcu_bus_pkg::word_t          cont_key0,
	input  mcu_bus_pkg::word_t          cont_key1,
	input  mcu_bus_pkg::word_t          cont_key2,
	input  mcu_bus_pkg::word_t          cont_key3,
	input  mcu_bus_pkg::word_t          cont_joy0,
	input  mcu_bus_pkg::word_t          cont_joy1,
	input  mcu_bus_pkg::word_t          cont_joy2,
	input  mcu_bus_pkg::word_t          cont_joy3,
	input  logic                        target_dataslot_ack,
	input  logic                        target_dataslot_done,
	input  mcu_dataslot_pkg::ds_err_t   target_dataslot_err,
	input  logic                        dataslot_update,
	input  mcu_dataslot_pkg::slot_id_t  dataslot_update_id,
	input  mcu_bus_pkg::word_t          dataslot_update_size,
	output logic                        target_dataslot_read,
	output logic                        target_dataslot_write,
	output mcu_dataslot_pkg::slot_id_t  target_dataslot_id,
	output mcu_bus_pkg::word_t          target_dataslot_bridgeaddr,
	output mcu_bus_pkg::word_t          target_dataslot_length,
	output mcu_bus_pkg::word_t          target_dataslot_slotoffset,
	output logic                        ext_irq,
	output logic                        timer_irq
);

	localparam int ID_PAD_W = `MCU_WORD_W - `MCU_SLOT_ID_W; // Zero fill for id reads

	mcu_bus_pkg::reg_offset_e   offset;
	logic                       in_window;
	logic                       wr_cmd;   // Write inside the window
	logic                       rd_cmd;   // Read inside the window
	mcu_bus_pkg::word_t         rd_word;  // Selected read word
	mcu_bus_pkg::word_t         sys_freq; // Shared by both timers
	mcu_bus_pkg::word_t         tmr1_cmp;
	logic                       tmr_en;   // Timer-1 irq enable
	mcu_bus_pkg::word_t         tmr1_count;
	mcu_bus_pkg::word_t         tmr2_count;
	logic                       tmr1_irq;
	mcu_bus_pkg::word_t         ds_status;
	logic                       upd_flag;
	mcu_dataslot_pkg::slot_id_t upd_id;
	mcu_bus_pkg::word_t         upd_size;

	// Window and offset decode, bits 15:8 not checked
	assign in_window = (dbus_addr[`MCU_ADDR_W-1:16] == `MCU_PERIPH_BASE);
	assign offset    = mcu_bus_pkg::reg_offset_e'(dbus_addr[`MCU_OFFSET_W-1:0]);
	assign wr_cmd    = dbus_valid & dbus_wr & in_window;
	assign rd_cmd    = dbus_valid & ~dbus_wr & in_window;

	target_dataslot_ctrl u_ds_ctrl (
		.clk_sys                    (clk_sys),
		.reset_n                    (reset_n),
		.wr_id                      (wr_cmd && offset == mcu_bus_pkg::DS_ID),
		.wr_bridge                  (wr_cmd && offset == mcu_bus_pkg::DS_BRIDGE),
		.wr_len                     (wr_cmd && offset == mcu_bus_pkg::DS_LEN),
		.wr_offset                  (wr_cmd && offset == mcu_bus_pkg::DS_OFFSET),
		.wr_ctrl                    (wr_cmd && offset == mcu_bus_pkg::DS_CTRL),
		.wdata                      (dbus_wdata),
		.target_dataslot_ack        (target_dataslot_ack),
		.target_dataslot_done       (target_dataslot_done),
		.target_dataslot_err        (target_dataslot_err),
		.target_dataslot_read       (target_dataslot_read),
		.target_dataslot_write      (target_dataslot_write),
		.target_dataslot_id         (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length     (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset),
		.status                     (ds_status),
		.ext_irq                    (ext_irq)
	);

	dataslot_update_capture u_upd (
		.clk_sys              (clk_sys),
		.reset_n              (reset_n),
		.dataslot_update      (dataslot_update),
		.dataslot_update_id   (dataslot_update_id),
		.dataslot_update_size (dataslot_update_size),
		.rd_flag              (rd_cmd && offset == mcu_bus_pkg::UPD_FLAG),
		.flag                 (upd_flag),
		.upd_id               (upd_id),
		.upd_size             (upd_size)
	);

	// Clear straight from the strobe so a following read sees it
	ms_timer tmr1 (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.clear    (wr_cmd && offset == mcu_bus_pkg::TMR1_COUNT && dbus_wdata[0]),
		.sys_freq (sys_freq),
		.compare  (tmr1_cmp),
		.count    (tmr1_count),
		.irq      (tmr1_irq)
	);

	ms_timer tmr2 (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.clear    (wr_cmd && offset == mcu_bus_pkg::TMR2_COUNT && dbus_wdata[0]),
		.sys_freq (sys_freq),
		.compare  ('0), // Free running, no match
		.count    (tmr2_count),
		.irq      ()
	);

	assign timer_irq = tmr_en & tmr1_irq;

	// Timer configuration registers
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			sys_freq <= '0;
			tmr1_cmp <= '0;
			tmr_en   <= 1'b0;
		end else if (wr_cmd) begin
			case (offset)
				mcu_bus_pkg::SYS_FREQ:   sys_freq <= dbus_wdata;
				mcu_bus_pkg::TMR1_COUNT: tmr_en <= 1'b0; // Any count write disarms
				mcu_bus_pkg::TMR1_CMP: begin
					tmr1_cmp <= dbus_wdata;
					tmr_en   <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Read mux, unknown offsets give zero
	always_comb begin
		case (offset)
			mcu_bus_pkg::KEY0:       rd_word = cont_key0;
			mcu_bus_pkg::KEY1:       rd_word = cont_key1;
			mcu_bus_pkg::KEY2:       rd_word = cont_key2;
			mcu_bus_pkg::KEY3:       rd_word = cont_key3;
			mcu_bus_pkg::JOY0:       rd_word = cont_joy0;
			mcu_bus_pkg::JOY1:       rd_word = cont_joy1;
			mcu_bus_pkg::JOY2:       rd_word = cont_joy2;
			mcu_bus_pkg::JOY3:       rd_word = cont_joy3;
			mcu_bus_pkg::DS_ID:      rd_word = {{ID_PAD_W{1'b0}}, target_dataslot_id};
			mcu_bus_pkg::DS_BRIDGE:  rd_word = target_dataslot_bridgeaddr;
			mcu_bus_pkg::DS_LEN:     rd_word = target_dataslot_length;
			mcu_bus_pkg::DS_OFFSET:  rd_word = target_dataslot_slotoffset;
			mcu_bus_pkg::DS_CTRL:    rd_word = ds_status;
			mcu_bus_pkg::SYS_FREQ:   rd_word = sys_freq;
			mcu_bus_pkg::UPD_FLAG:   rd_word = mcu_bus_pkg::word_t'(upd_flag);
			mcu_bus_pkg::UPD_ID:     rd_word = {{ID_PAD_W{1'b0}}, upd_id};
			mcu_bus_pkg::UPD_SIZE:   rd_word = upd_size;
			mcu_bus_pkg::TMR1_COUNT: rd_word = tmr1_count;
			mcu_bus_pkg::TMR1_CMP:   rd_word = tmr1_cmp;
			mcu_bus_pkg::TMR2_COUNT: rd_word = tmr2_count;
			mcu_bus_pkg::TMR_STATE:  rd_word = mcu_bus_pkg::word_t'({timer_irq, tmr_en});
			default:                 rd_word = '0;
		endcase
	end

	// One response per command, writes and misses return zero
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			dbus_rsp_ready <= 1'b0;
			dbus_rsp_data  <= '0;
		end else begin
			dbus_rsp_ready <= dbus_valid;
			dbus_rsp_data  <= rd_cmd ? rd_word : '0;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_mcu_periph.sv ====
/*
 * Testbench for the peripheral register block. Drives bus commands and host
 * levels, predicts each response word from a register model, checks ports.
 */
`default_nettype none

`include "mcu_defs.svh"

module tb_mcu_periph;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int WATCHDOG_CYCLES = 2000; // About ten times the expected run

	logic                       clk_sys;
	logic                       reset_n;
	logic                       dbus_valid;
	logic                       dbus_wr;
	mcu_bus_pkg::addr_t         dbus_addr;
	mcu_bus_pkg::word_t         dbus_wdata;
	logic                       dbus_rsp_ready;
	mcu_bus_pkg::word_t         dbus_rsp_data;
	mcu_bus_pkg::word_t         cont_key [4];
	mcu_bus_pkg::word_t         cont_joy [4];
	logic                       target_dataslot_ack;
	logic                       target_dataslot_done;
	mcu_dataslot_pkg::ds_err_t  target_dataslot_err;
	logic                       dataslot_update;
	mcu_dataslot_pkg::slot_id_t dataslot_update_id;
	mcu_bus_pkg::word_t         dataslot_update_size;
	logic                       target_dataslot_read;
	logic                       target_dataslot_write;
	mcu_dataslot_pkg::slot_id_t target_dataslot_id;
	mcu_bus_pkg::word_t         target_dataslot_bridgeaddr;
	mcu_bus_pkg::word_t         target_dataslot_length;
	mcu_bus_pkg::word_t         target_dataslot_slotoffset;
	logic                       ext_irq;
	logic                       timer_irq;

	// Register model updated as each command is driven
	mcu_dataslot_pkg::slot_id_t m_ds_id;
	mcu_dataslot_pkg::slot_id_t m_upd_id;
	mcu_bus_pkg::word_t         m_bridge, m_len, m_offset, m_sys_freq, m_tmr_cmp, m_upd_size;
	logic                       m_upd_flag;
	logic                       m_tmr_en;
	int                         m_clear_edge; // Edge that drove the last timer-1 clear

	mcu_bus_pkg::word_t exp_q [$]; // Expected response words in issue order
	int                 edge_num;
	int                 resp_errors;
	int                 port_errors;
	integer             seed = 64;

	mcu_periph_bus DUT (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.dbus_valid (dbus_valid), .dbus_wr (dbus_wr),
		.dbus_addr (dbus_addr), .dbus_wdata (dbus_wdata),
		.dbus_rsp_ready (dbus_rsp_ready), .dbus_rsp_data (dbus_rsp_data),
		.cont_key0 (cont_key[0]), .cont_key1 (cont_key[1]),
		.cont_key2 (cont_key[2]), .cont_key3 (cont_key[3]),
		.cont_joy0 (cont_joy[0]), .cont_joy1 (cont_joy[1]),
		.cont_joy2 (cont_joy[2]), .cont_joy3 (cont_joy[3]),
		.target_dataslot_ack (target_dataslot_ack),
		.target_dataslot_done (target_dataslot_done),
		.target_dataslot_err (target_dataslot_err),
		.dataslot_update (dataslot_update),
		.dataslot_update_id (dataslot_update_id),
		.dataslot_update_size (dataslot_update_size),
		.target_dataslot_read (target_dataslot_read),
		.target_dataslot_write (target_dataslot_write),
		.target_dataslot_id (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset),
		.ext_irq (ext_irq), .timer_irq (timer_irq)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	task automatic check_word(input mcu_bus_pkg::word_t got, input mcu_bus_pkg::word_t exp,
		input string what, inout int errs);
		if (got !== exp) begin
			errs++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_slot_id(input mcu_dataslot_pkg::slot_id_t got,
		input mcu_dataslot_pkg::slot_id_t exp, input string what, inout int errs);
		if (got !== exp) begin
			errs++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pulse(input logic got, input logic exp, input string what,
		inout int errs);
		if (got !== exp) begin
			errs++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic mcu_bus_pkg::addr_t win(input logic [7:0] off);
		return {`MCU_PERIPH_BASE, 8'h00, off}; // Bits 15:8 left at zero
	endfunction

	// Timer 1 count after edge e with one step every sys_freq+1 cycles
	function automatic mcu_bus_pkg::word_t tmr1_count_at(input int e);
		return mcu_bus_pkg::word_t'((e - m_clear_edge - 1) / (m_sys_freq + 1));
	endfunction

	// Sticky once the count has stepped past a nonzero compare
	function automatic logic tmr1_irq_at(input int e);
		return m_tmr_en && m_tmr_cmp != '0 && tmr1_count_at(e) > m_tmr_cmp;
	endfunction

	// Expected response for a command driven at edge e
	function automatic mcu_bus_pkg::word_t ref_word(input logic wr,
		input mcu_bus_pkg::addr_t addr, input int e);
		if (wr || addr[31:16] != `MCU_PERIPH_BASE)
			return '0; // Writes and misses answer zero
		case (mcu_bus_pkg::reg_offset_e'(addr[7:0]))
			mcu_bus_pkg::KEY0:       return cont_key[0];
			mcu_bus_pkg::KEY1:       return cont_key[1];
			mcu_bus_pkg::KEY2:       return cont_key[2];
			mcu_bus_pkg::KEY3:       return cont_key[3];
			mcu_bus_pkg::JOY0:       return cont_joy[0];
			mcu_bus_pkg::JOY1:       return cont_joy[1];
			mcu_bus_pkg::JOY2:       return cont_joy[2];
			mcu_bus_pkg::JOY3:       return cont_joy[3];
			mcu_bus_pkg::DS_ID:      return {16'h0, m_ds_id};
			mcu_bus_pkg::DS_BRIDGE:  return m_bridge;
			mcu_bus_pkg::DS_LEN:     return m_len;
			mcu_bus_pkg::DS_OFFSET:  return m_offset;
			mcu_bus_pkg::DS_CTRL:    return {27'h0, target_dataslot_ack, target_dataslot_done,
				target_dataslot_err}; // Live status
			mcu_bus_pkg::SYS_FREQ:   return m_sys_freq;
			mcu_bus_pkg::UPD_FLAG:   return {31'h0, m_upd_flag};
			mcu_bus_pkg::UPD_ID:     return {16'h0, m_upd_id};
			mcu_bus_pkg::UPD_SIZE:   return m_upd_size;
			mcu_bus_pkg::TMR1_COUNT: return tmr1_count_at(e);
			mcu_bus_pkg::TMR1_CMP:   return m_tmr_cmp;
			mcu_bus_pkg::TMR_STATE:  return {30'h0, tmr1_irq_at(e), m_tmr_en};
			default:                 return '0;
		endcase
	endfunction

	task automatic apply_write(input mcu_bus_pkg::addr_t addr, input mcu_bus_pkg::word_t wdata);
		if (addr[31:16] == `MCU_PERIPH_BASE) begin
			case (mcu_bus_pkg::reg_offset_e'(addr[7:0]))
				mcu_bus_pkg::DS_ID:     m_ds_id = wdata[`MCU_SLOT_ID_W-1:0];
				mcu_bus_pkg::DS_BRIDGE: m_bridge = wdata;
				mcu_bus_pkg::DS_LEN:    m_len = wdata;
				mcu_bus_pkg::DS_OFFSET: m_offset = wdata;
				mcu_bus_pkg::SYS_FREQ:  m_sys_freq = wdata;
				mcu_bus_pkg::TMR1_COUNT: begin
					m_tmr_en = 1'b0; // Any count write disarms
					if (wdata[0])
						m_clear_edge = edge_num;
				end
				mcu_bus_pkg::TMR1_CMP: begin
					m_tmr_cmp = wdata;
					m_tmr_en  = 1'b1;
				end
				default: ;
			endcase
		end
	endtask

	task automatic step();
		@(posedge clk_sys);
		edge_num++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			step();
			dbus_valid <= 1'b0;
		end
	endtask

	// Drives one command that stays on the bus until the next step
	task automatic bus_cmd(input logic wr, input mcu_bus_pkg::addr_t addr,
		input mcu_bus_pkg::word_t wdata);
		step();
		dbus_valid <= 1'b1;
		dbus_wr    <= wr;
		dbus_addr  <= addr;
		dbus_wdata <= wdata;
		exp_q.push_back(ref_word(wr, addr, edge_num));
		if (wr)
			apply_write(addr, wdata);
		else if (addr == win(mcu_bus_pkg::UPD_FLAG))
			m_upd_flag = 1'b0; // Read clears
	endtask

	// Response checker sampling on the falling edge
	always @(negedge clk_sys) begin
		if (dbus_rsp_ready) begin
			if (exp_q.size() == 0) begin
				resp_errors++;
				$display("Response at %0t ns arrived with no command outstanding", $time);
			end else begin
				check_word(dbus_rsp_data, exp_q.pop_front(), "dbus_rsp_data", resp_errors);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired, the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		mcu_bus_pkg::word_t r;
		mcu_bus_pkg::addr_t a;
		logic [7:0]         off;
		reset_n = 1'b0;
		dbus_valid = 1'b0;
		dbus_wr = 1'b0;
		dbus_addr = '0;
		dbus_wdata = '0;
		foreach (cont_key[k]) begin
			cont_key[k] = '0;
			cont_joy[k] = '0;
		end
		target_dataslot_ack = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err = '0;
		dataslot_update = 1'b0;
		dataslot_update_id = '0;
		dataslot_update_size = '0;
		{m_ds_id, m_upd_id, m_bridge, m_len, m_offset} = '0;
		{m_sys_freq, m_tmr_cmp, m_upd_size, m_upd_flag, m_tmr_en} = '0;
		{m_clear_edge, edge_num, resp_errors, port_errors} = '0;
		repeat (10) step();
		reset_n <= 1'b1;
		idle(2);

		// Back-to-back parameter writes then reads
		for (int i = 0; i < 4; i++) begin
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_ID), $random(seed));
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_BRIDGE), $random(seed));
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_LEN), $random(seed));
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_OFFSET), $random(seed));
			bus_cmd(1'b1, win(mcu_bus_pkg::SYS_FREQ), $random(seed));
			bus_cmd(1'b0, win(mcu_bus_pkg::DS_ID), '0);
			bus_cmd(1'b0, win(mcu_bus_pkg::DS_BRIDGE), '0);
			bus_cmd(1'b0, win(mcu_bus_pkg::DS_LEN), '0);
			bus_cmd(1'b0, win(mcu_bus_pkg::DS_OFFSET), '0);
			bus_cmd(1'b0, win(mcu_bus_pkg::SYS_FREQ), '0);
			idle(1);
			@(negedge clk_sys);
			check_slot_id(target_dataslot_id, m_ds_id, "target_dataslot_id", port_errors);
			check_word(target_dataslot_bridgeaddr, m_bridge, "bridgeaddr", port_errors);
			check_word(target_dataslot_length, m_len, "length", port_errors);
			check_word(target_dataslot_slotoffset, m_offset, "slotoffset", port_errors);
		end

		// Controller words
		step();
		foreach (cont_key[k]) begin
			cont_key[k] <= $random(seed);
			cont_joy[k] <= $random(seed);
		end
		off = mcu_bus_pkg::KEY0;
		for (int i = 0; i < 8; i++) begin
			bus_cmd(1'b0, win(off), '0);
			off = off + 8'd4; // KEY0 to JOY3 are contiguous
		end

		// Misses and unknown offsets
		a = $random(seed);
		a[31] = 1'b0; // Never the window
		a[15:0] = {8'h00, mcu_bus_pkg::DS_BRIDGE};
		bus_cmd(1'b1, a, $random(seed));
		bus_cmd(1'b0, a, '0);
		bus_cmd(1'b0, win(mcu_bus_pkg::DS_BRIDGE), '0);
		bus_cmd(1'b1, win(8'h94), $random(seed));
		bus_cmd(1'b0, win(8'h94), '0);
		bus_cmd(1'b0, win(8'h00), '0);
		bus_cmd(1'b0, win(8'hFC), '0);
		idle(1);
		@(negedge clk_sys);
		check_word(target_dataslot_bridgeaddr, m_bridge, "bridgeaddr after miss", port_errors);

		// Command pulses then status readback
		for (int v = 1; v <= 3; v++) begin
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_CTRL), v);
			idle(1);
			@(negedge clk_sys);
			check_pulse(target_dataslot_read, v[0], "target_dataslot_read", port_errors);
			check_pulse(target_dataslot_write, v[1], "target_dataslot_write", port_errors);
			idle(1);
			@(negedge clk_sys);
			check_pulse(target_dataslot_read, 1'b0, "read pulse end", port_errors);
			check_pulse(target_dataslot_write, 1'b0, "write pulse end", port_errors);
		end
		for (int i = 0; i < 4; i++) begin
			step();
			r = $random(seed);
			target_dataslot_ack  <= r[4];
			target_dataslot_done <= r[3];
			target_dataslot_err  <= r[2:0];
			bus_cmd(1'b0, win(mcu_bus_pkg::DS_CTRL), '0);
			idle(1);
		end

		// Done edge with the interrupt enabled and then disabled
		for (int en = 1; en >= 0; en--) begin
			step();
			target_dataslot_done <= 1'b0;
			bus_cmd(1'b1, win(mcu_bus_pkg::DS_CTRL), en == 1 ? 32'h4 : 32'h0);
			idle(3);
			target_dataslot_done <= 1'b1;
			for (int k = 1; k <= 4; k++) begin
				step();
				@(negedge clk_sys);
				check_pulse(ext_irq, en == 1 && k == 2, "ext_irq", port_errors);
			end
		end

		// Update capture
		step();
		r = $random(seed);
		dataslot_update    <= 1'b1;
		dataslot_update_id <= r[15:0];
		m_upd_id = r[15:0];
		r = $random(seed);
		dataslot_update_size <= r;
		m_upd_size = r;
		m_upd_flag = 1'b1;
		step();
		dataslot_update      <= 1'b0;
		dataslot_update_id   <= ~m_upd_id; // Inputs move on after the pulse
		dataslot_update_size <= ~m_upd_size;
		bus_cmd(1'b0, win(mcu_bus_pkg::UPD_FLAG), '0);
		bus_cmd(1'b0, win(mcu_bus_pkg::UPD_FLAG), '0); // Cleared by the first read
		bus_cmd(1'b0, win(mcu_bus_pkg::UPD_ID), '0);
		bus_cmd(1'b0, win(mcu_bus_pkg::UPD_SIZE), '0);

		// Timer count and compare irq
		bus_cmd(1'b1, win(mcu_bus_pkg::SYS_FREQ), 32'd3);
		bus_cmd(1'b1, win(mcu_bus_pkg::TMR1_COUNT), 32'd1);
		idle(40);
		bus_cmd(1'b0, win(mcu_bus_pkg::TMR1_COUNT), '0);
		bus_cmd(1'b1, win(mcu_bus_pkg::TMR1_COUNT), 32'd1); // Restart below the compare
		bus_cmd(1'b1, win(mcu_bus_pkg::TMR1_CMP), 32'd2);
		idle(16);
		@(negedge clk_sys);
		check_pulse(timer_irq, tmr1_irq_at(edge_num), "timer_irq after compare", port_errors);
		bus_cmd(1'b0, win(mcu_bus_pkg::TMR_STATE), '0);
		bus_cmd(1'b0, win(mcu_bus_pkg::TMR1_CMP), '0);
		bus_cmd(1'b0, win(mcu_bus_pkg::TMR1_COUNT), '0);
		bus_cmd(1'b1, win(mcu_bus_pkg::TMR1_COUNT), 32'd1);
		bus_cmd(1'b1, win(mcu_bus_pkg::TMR1_CMP), 32'd2); // Re-armed, latched irq must be gone
		idle(1);
		@(negedge clk_sys);
		check_pulse(timer_irq, tmr1_irq_at(edge_num), "timer_irq after clear", port_errors);
		bus_cmd(1'b0, win(mcu_bus_pkg::TMR_STATE), '0);
		idle(4);

		if (exp_q.size() != 0) begin
			port_errors++;
			$display("%0d responses never arrived", exp_q.size());
		end
		$display("Errors: %0d in responses, %0d in ports", resp_errors, port_errors);
		if (resp_errors + port_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/mcu_bus_pkg.sv
common/mcu_dataslot_pkg.sv
logic/ms_timer.sv
dataslot/target_dataslot_ctrl.sv
dataslot/dataslot_update_capture.sv
logic/mcu_periph_bus.sv
test/tb_mcu_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f src.f \
	--top-module tb_mcu_periph -Mdir obj_dir
./obj_dir/Vtb_mcu_periph > sim.log
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
